// ==== vlog.f ====
+incdir+include
rtl/thread_pkg.sv
rtl/wb_pkg.sv
rtl/thread_cmd_decoder.sv
rtl/thread_table.sv
rtl/thread_scheduler.sv
rtl/threads_manager.sv
testbench/tb_threads_manager.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 -f vlog.f --top-module tb_threads_manager -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run_sim: failure reported in sim.log"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "run_sim: simulation ended without a result"
  exit 1
fi
exit 0

// ==== include/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// model of the thread loop, kept in step with the DUT
thread_desc_t tbl_q[$];
int           sleep_q[$];
int           cursor;
logic         fork_pend;
thread_desc_t fork_desc;
logic         stop_pend;
thread_desc_t stop_desc;
int           stop_seen;
logic         pause_pend;
thread_desc_t pause_desc;
int           pause_seen;

logic [31:0]  lfsr_q = 32'h09c6_7278;
string        test_name;
int           test_errs;

function automatic void clear_model();
  tbl_q.delete();
  sleep_q.delete();
  cursor     = 0;
  // boot thread waits in the fork slot
  fork_pend  = 1'b1;
  fork_desc  = '0;
  stop_pend  = 1'b0;
  stop_desc  = '0;
  stop_seen  = 0;
  pause_pend = 1'b0;
  pause_desc = '0;
  pause_seen = 0;
endfunction

// a command lands only in an empty slot
function automatic logic slot_accepts(input thread_cmd_e cmd, input thread_desc_t d);
  logic acc;
  acc = 1'b0;
  case (cmd)
    CMD_RUN: begin
      if (!fork_pend) begin
        fork_pend = 1'b1;
        fork_desc = d;
        acc       = 1'b1;
      end
    end
    CMD_STOP: begin
      if (!stop_pend) begin
        stop_pend = 1'b1;
        stop_desc = d;
        stop_seen = 0;
        acc       = 1'b1;
      end
    end
    CMD_PAUSE: begin
      if (!pause_pend) begin
        pause_pend = 1'b1;
        pause_desc = d;
        pause_seen = 0;
        acc        = 1'b1;
      end
    end
    default: acc = 1'b0;
  endcase
  return acc;
endfunction

// next thread handed out, walking the loop like the scheduler
function automatic thread_desc_t predict_next();
  thread_desc_t res;
  int           cnt;
  int           cur;
  logic         s_hit;
  logic         p_hit;
  logic         done;
  res  = '0;
  done = 1'b0;
  // pending fork wins unless the table is full
  if (fork_pend && tbl_q.size() < PROC_QUANTITY) begin
    tbl_q.push_back(fork_desc);
    sleep_q.push_back(0);
    fork_pend = 1'b0;
    res       = fork_desc;
    done      = 1'b1;
  end
  while (!done && tbl_q.size() > 0) begin
    cnt   = tbl_q.size();
    cur   = cursor;
    s_hit = stop_pend && (tbl_q[cur] == stop_desc);
    p_hit = pause_pend && (tbl_q[cur] == pause_desc);
    if (stop_pend) begin
      stop_seen++;
    end
    if (pause_pend) begin
      pause_seen++;
    end
    // whole loop seen without a match
    if (stop_pend && !s_hit && stop_seen >= cnt) begin
      stop_pend = 1'b0;
    end
    if (pause_pend && !p_hit && pause_seen >= cnt) begin
      pause_pend = 1'b0;
    end
    if (p_hit) begin
      sleep_q[cur] = SLEEP_TICKS;
      pause_pend   = 1'b0;
      cursor       = (cur + 1 == cnt) ? 0 : cur + 1;
    end else if (s_hit && cnt > 1) begin
      // last entry moves into the hole
      tbl_q[cur]   = tbl_q[cnt - 1];
      sleep_q[cur] = sleep_q[cnt - 1];
      void'(tbl_q.pop_back());
      void'(sleep_q.pop_back());
      stop_pend = 1'b0;
      cursor    = (cur == cnt - 1) ? 0 : cur;
    end else begin
      // stop on the only thread just goes away
      if (s_hit) begin
        stop_pend = 1'b0;
      end
      cursor = (cur + 1 == cnt) ? 0 : cur + 1;
      if (sleep_q[cur] != 0) begin
        sleep_q[cur] = sleep_q[cur] - 1;
      end else begin
        res  = tbl_q[cur];
        done = 1'b1;
      end
    end
  end
  return res;
endfunction

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per descriptor bit
function automatic thread_desc_t random_desc();
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < 32; i++) begin
    lfsr_q = lfsr_step(lfsr_q);
    v      = {v[30:0], lfsr_q[0]};
  end
  return v;
endfunction

task automatic check_eq(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
  if (act_v !== exp_v) begin
    $display("FAIL %s expected %h actual %h", name, exp_v, act_v);
    test_errs++;
  end
endtask

`endif

// ==== testbench/tb_threads_manager.sv ====
`timescale 1ns/100ps

module tb_threads_manager
  import thread_pkg::*, wb_pkg::*;
;

  localparam int PROC_QUANTITY  = 8;
  localparam int SLEEP_TICKS    = 4;
  // upper bound on commands plus next-thread requests
  localparam int REQ_COUNT      = 90;
  localparam int TIMEOUT_CYCLES = 20 * REQ_COUNT * PROC_QUANTITY;

  logic         clk = 1'b0;
  logic         rst;
  wb_req_t      wb_req;
  wb_rsp_t      wb_rsp;
  logic         next_thread_i;
  thread_desc_t next_proc_o;
  logic         next_valid_o;

  thread_desc_t exp_q[$];
  int           tests_run;
  int           tests_failed;
  int           total_errs;
  int           cycles;

  `include "tb_ref_model.svh"

  threads_manager #(
    .PROC_QUANTITY (PROC_QUANTITY),
    .SLEEP_TICKS   (SLEEP_TICKS)
  ) threads_manager_inst (
    .clk           (clk),
    .rst           (rst),
    .wb_req_i      (wb_req),
    .wb_rsp_o      (wb_rsp),
    .next_thread_i (next_thread_i),
    .next_proc_o   (next_proc_o),
    .next_valid_o  (next_valid_o)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // compare each handed-out thread, mid-cycle
  always @(negedge clk) begin
    thread_desc_t exp_d;
    if (!rst && next_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("test %s: next_valid_o pulsed with no request outstanding", test_name);
        test_errs++;
      end else begin
        exp_d = exp_q.pop_front();
        check_eq(test_name, exp_d, next_proc_o);
      end
    end
  end

  // classic single write, held until ack
  task automatic wb_write(input thread_cmd_e cmd, input thread_desc_t d,
                          output logic [31:0] rsp_dat);
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b1;
    wb_req.adr = cmd;
    wb_req.dat = d;
    do begin
      @(posedge clk);
      #1;
    end while (!wb_rsp.ack);
    rsp_dat = wb_rsp.dat;
    wb_req  = '0;
    // ack is a single cycle pulse
    @(posedge clk);
    #1;
    check_eq({test_name, " ack"}, 32'd0, 32'(wb_rsp.ack));
  endtask

  task automatic send_cmd(input thread_cmd_e cmd, input thread_desc_t d);
    logic        exp_acc;
    logic [31:0] act_dat;
    exp_acc = slot_accepts(cmd, d);
    wb_write(cmd, d, act_dat);
    // whole reply word is 1 or 0
    check_eq({test_name, " accepted"}, 32'(exp_acc), act_dat);
  endtask

  // one request pulse, then wait for the thread and its check
  task automatic next_thread();
    exp_q.push_back(predict_next());
    @(posedge clk);
    #1;
    next_thread_i = 1'b1;
    @(posedge clk);
    #1;
    next_thread_i = 1'b0;
    while (!next_valid_o) begin
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    #1;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (exp_q.size() != 0) begin
      $display("test %s: %0d expected threads never came out", test_name, exp_q.size());
      test_errs++;
      exp_q.delete();
    end
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, test_errs);
    end
  endtask

  // hang guard
  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: test %s still running after %0d cycles", test_name, cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    int pause_reqs;
    rst           = 1'b1;
    next_thread_i = 1'b0;
    wb_req        = '0;
    tests_run     = 0;
    tests_failed  = 0;
    total_errs    = 0;
    clear_model();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // boot fork still holds the slot
    start_test("boot");
    send_cmd(CMD_RUN, random_desc());
    next_thread();
    end_test();

    start_test("fork");
    send_cmd(CMD_RUN, random_desc());
    send_cmd(CMD_RUN, random_desc());
    next_thread();
    end_test();

    // five threads in the loop
    start_test("round_robin");
    for (int i = 0; i < 3; i++) begin
      send_cmd(CMD_RUN, random_desc());
      next_thread();
    end
    for (int i = 0; i < 10; i++) begin
      next_thread();
    end
    end_test();

    start_test("stop");
    send_cmd(CMD_STOP, tbl_q[2]);
    send_cmd(CMD_STOP, tbl_q[1]);
    for (int i = 0; i < 6; i++) begin
      next_thread();
    end
    // absent thread, dropped after a sweep
    send_cmd(CMD_STOP, random_desc());
    for (int i = 0; i < 6; i++) begin
      next_thread();
    end
    end_test();

    // enough rounds for the sleeper to sit out its turns and come back
    start_test("pause");
    send_cmd(CMD_PAUSE, tbl_q[1]);
    pause_reqs = (SLEEP_TICKS + 2) * tbl_q.size();
    for (int i = 0; i < pause_reqs; i++) begin
      next_thread();
    end
    end_test();

    // fork left waiting on a full table
    start_test("full");
    while (tbl_q.size() < PROC_QUANTITY) begin
      send_cmd(CMD_RUN, random_desc());
      next_thread();
    end
    send_cmd(CMD_RUN, random_desc());
    send_cmd(CMD_RUN, random_desc());
    for (int i = 0; i < 2 * PROC_QUANTITY; i++) begin
      next_thread();
    end
    end_test();

    $display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== rtl/threads_manager.sv ====
`timescale 1ns/100ps

module threads_manager
  import thread_pkg::*, wb_pkg::*;
#(
  parameter int PROC_QUANTITY = 8,
  parameter int SLEEP_TICKS   = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  wb_req_t      wb_req_i,
  output wb_rsp_t      wb_rsp_o,
  input  logic         next_thread_i,
  output thread_desc_t next_proc_o,
  output logic         next_valid_o
);

  sched_req_t sched_req;
  sched_ack_t sched_ack;
  tbl_cmd_t   tbl_cmd;
  tbl_rsp_t   tbl_rsp;

  // cpu commands into pending slots
  thread_cmd_decoder thread_cmd_decoder_inst (
    .clk         (clk),
    .rst         (rst),
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .sched_req_o (sched_req),
    .sched_ack_i (sched_ack)
  );

  // active thread loop
  thread_table #(
    .PROC_QUANTITY (PROC_QUANTITY)
  ) thread_table_inst (
    .clk       (clk),
    .rst       (rst),
    .tbl_cmd_i (tbl_cmd),
    .tbl_rsp_o (tbl_rsp)
  );

  // round robin walker
  thread_scheduler #(
    .PROC_QUANTITY (PROC_QUANTITY),
    .SLEEP_TICKS   (SLEEP_TICKS)
  ) thread_scheduler_inst (
    .clk           (clk),
    .rst           (rst),
    .next_thread_i (next_thread_i),
    .next_proc_o   (next_proc_o),
    .next_valid_o  (next_valid_o),
    .sched_req_i   (sched_req),
    .sched_ack_o   (sched_ack),
    .tbl_cmd_o     (tbl_cmd),
    .tbl_rsp_i     (tbl_rsp)
  );

endmodule

// ==== rtl/thread_scheduler.sv ====
`timescale 1ns/100ps

module thread_scheduler
  import thread_pkg::*;
#(
  parameter int PROC_QUANTITY = 8,
  parameter int SLEEP_TICKS   = 4
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         next_thread_i,
  output thread_desc_t next_proc_o,
  output logic         next_valid_o,
  input  sched_req_t   sched_req_i,
  output sched_ack_t   sched_ack_o,
  output tbl_cmd_t     tbl_cmd_o,
  input  tbl_rsp_t     tbl_rsp_i
);

  localparam logic [IDX_W-1:0]   MAX_COUNT = IDX_W'(PROC_QUANTITY);
  localparam logic [SLEEP_W-1:0] SLEEP_VAL = SLEEP_W'(SLEEP_TICKS);

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_EVAL
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic [IDX_W-1:0] cursor_q;
  logic [IDX_W-1:0] cursor_d;
  logic [IDX_W-1:0] cursor_inc;
  logic [IDX_W-1:0] cursor_next;
  logic [IDX_W-1:0] last_idx;
  // entries compared against each pending request so far
  logic [IDX_W-1:0] stop_cnt_q;
  logic [IDX_W-1:0] pause_cnt_q;
  logic             fork_ok;
  logic             stop_hit;
  logic             pause_hit;
  logic             stop_miss;
  logic             pause_miss;
  logic             emit;
  thread_desc_t     emit_desc;
  thread_desc_t     next_proc_q;
  logic             next_valid_q;

  // wrap at the live count
  assign cursor_inc  = cursor_q + 1'b1;
  assign cursor_next = (cursor_inc == tbl_rsp_i.count) ? '0 : cursor_inc;
  assign last_idx    = tbl_rsp_i.count - 1'b1;

  // pending fork goes first unless the table is full
  assign fork_ok = sched_req_i.fork_slot.vld & (tbl_rsp_i.count != MAX_COUNT);

  // compare the entry just read
  assign pause_hit = sched_req_i.pause_slot.vld & (tbl_rsp_i.desc == sched_req_i.pause_slot.desc);
  assign stop_hit  = sched_req_i.stop_slot.vld & (tbl_rsp_i.desc == sched_req_i.stop_slot.desc);

  // full sweep without a match drops the request
  assign pause_miss = sched_req_i.pause_slot.vld & ~pause_hit &
                      (pause_cnt_q + 1'b1 >= tbl_rsp_i.count);
  assign stop_miss  = sched_req_i.stop_slot.vld & ~stop_hit &
                      (stop_cnt_q + 1'b1 >= tbl_rsp_i.count);

  always_comb begin
    tbl_cmd_o   = '{op: TBL_NONE, idx: cursor_q, desc: sched_req_i.fork_slot.desc, sleep: '0};
    sched_ack_o = '0;
    state_d     = state_q;
    cursor_d    = cursor_q;
    emit        = 1'b0;
    emit_desc   = tbl_rsp_i.desc;
    case (state_q)
      S_IDLE: begin
        if (next_thread_i) begin
          if (fork_ok) begin
            // fork is appended and handed out, cursor untouched
            tbl_cmd_o.op           = TBL_APPEND;
            sched_ack_o.fork_taken = 1'b1;
            emit                   = 1'b1;
            emit_desc              = sched_req_i.fork_slot.desc;
          end else begin
            state_d = S_READ;
          end
        end
      end
      S_READ: begin
        tbl_cmd_o.op = TBL_READ;
        state_d      = S_EVAL;
      end
      S_EVAL: begin
        state_d                = S_READ;
        sched_ack_o.stop_done  = stop_miss;
        sched_ack_o.pause_done = pause_miss;
        if (pause_hit) begin
          tbl_cmd_o.op           = TBL_SET_SLEEP;
          tbl_cmd_o.sleep        = SLEEP_VAL;
          sched_ack_o.pause_done = 1'b1;
          cursor_d               = cursor_next;
        end else if (stop_hit && tbl_rsp_i.count > 4'd1) begin
          // swapped-in entry gets read at the same slot
          tbl_cmd_o.op          = TBL_REMOVE;
          sched_ack_o.stop_done = 1'b1;
          cursor_d              = (cursor_q == last_idx) ? '0 : cursor_q;
        end else begin
          // stop on the only thread is just dropped
          if (stop_hit) begin
            sched_ack_o.stop_done = 1'b1;
          end
          cursor_d = cursor_next;
          if (tbl_rsp_i.sleep != '0) begin
            tbl_cmd_o.op    = TBL_SET_SLEEP;
            tbl_cmd_o.sleep = tbl_rsp_i.sleep - 1'b1;
          end else begin
            emit    = 1'b1;
            state_d = S_IDLE;
          end
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= S_IDLE;
      cursor_q     <= '0;
      next_valid_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      cursor_q     <= cursor_d;
      next_valid_q <= emit;
    end
  end

  // sweep counters restart whenever their slot is empty
  always_ff @(posedge clk) begin
    if (rst || !sched_req_i.stop_slot.vld) begin
      stop_cnt_q <= '0;
    end else if (state_q == S_EVAL) begin
      stop_cnt_q <= stop_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !sched_req_i.pause_slot.vld) begin
      pause_cnt_q <= '0;
    end else if (state_q == S_EVAL) begin
      pause_cnt_q <= pause_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      next_proc_q <= emit_desc;
    end
  end

  assign next_proc_o  = next_proc_q;
  assign next_valid_o = next_valid_q;

endmodule

// ==== rtl/thread_table.sv ====
`timescale 1ns/100ps

module thread_table
  import thread_pkg::*;
#(
  parameter int PROC_QUANTITY = 8
) (
  input  logic     clk,
  input  logic     rst,
  input  tbl_cmd_t tbl_cmd_i,
  output tbl_rsp_t tbl_rsp_o
);

  // depth limit as a count value
  localparam logic [IDX_W-1:0] MAX_COUNT = IDX_W'(PROC_QUANTITY);

  // full index range, entries past PROC_QUANTITY are never written
  thread_desc_t       desc_mem  [1 << IDX_W];
  logic [SLEEP_W-1:0] sleep_mem [1 << IDX_W];

  logic [IDX_W-1:0]   count_q;
  thread_desc_t       rd_desc_q;
  logic [SLEEP_W-1:0] rd_sleep_q;
  logic [IDX_W-1:0]   last_idx;
  logic               full;
  logic               can_remove;

  assign last_idx   = count_q - 1'b1;
  assign full       = (count_q == MAX_COUNT);
  // the last thread always stays in the loop
  assign can_remove = (count_q > 4'd1);

  always_ff @(posedge clk) begin
    case (tbl_cmd_i.op)
      TBL_APPEND: begin
        // new threads start awake
        if (!full) begin
          desc_mem[count_q]  <= tbl_cmd_i.desc;
          sleep_mem[count_q] <= '0;
        end
      end
      TBL_READ: begin
        rd_desc_q  <= desc_mem[tbl_cmd_i.idx];
        rd_sleep_q <= sleep_mem[tbl_cmd_i.idx];
      end
      TBL_SET_SLEEP: begin
        sleep_mem[tbl_cmd_i.idx] <= tbl_cmd_i.sleep;
      end
      TBL_REMOVE: begin
        // last entry fills the hole
        if (can_remove) begin
          desc_mem[tbl_cmd_i.idx]  <= desc_mem[last_idx];
          sleep_mem[tbl_cmd_i.idx] <= sleep_mem[last_idx];
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (tbl_cmd_i.op == TBL_APPEND && !full) begin
      count_q <= count_q + 1'b1;
    end else if (tbl_cmd_i.op == TBL_REMOVE && can_remove) begin
      count_q <= last_idx;
    end
  end

  assign tbl_rsp_o.desc  = rd_desc_q;
  assign tbl_rsp_o.sleep = rd_sleep_q;
  assign tbl_rsp_o.count = count_q;

endmodule

// ==== rtl/thread_cmd_decoder.sv ====
`timescale 1ns/100ps

module thread_cmd_decoder
  import thread_pkg::*, wb_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  wb_req_t    wb_req_i,
  output wb_rsp_t    wb_rsp_o,
  output sched_req_t sched_req_o,
  input  sched_ack_t sched_ack_i
);

  logic       ack_q;
  logic       acc_q;
  sched_req_t req_q;
  logic       cmd_new;
  logic       slot_free;
  logic       accept;

  // first cycle of a strobe, ack not yet given
  assign cmd_new = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

  // a command only lands in an empty slot
  always_comb begin
    case (wb_req_i.adr)
      CMD_RUN:   slot_free = ~req_q.fork_slot.vld;
      CMD_STOP:  slot_free = ~req_q.stop_slot.vld;
      CMD_PAUSE: slot_free = ~req_q.pause_slot.vld;
      default:   slot_free = 1'b0;
    endcase
  end

  // reads get acked but never accepted
  assign accept = cmd_new & wb_req_i.we & slot_free;

  // single cycle ack, one clock after the strobe is seen
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= cmd_new;
    end
  end

  // accepted flag, only meaningful with ack
  always_ff @(posedge clk) begin
    if (cmd_new) begin
      acc_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // boot thread 0 waits for its fork
      req_q.fork_slot.vld   <= 1'b1;
      req_q.fork_slot.desc  <= '0;
      req_q.stop_slot.vld   <= 1'b0;
      req_q.pause_slot.vld  <= 1'b0;
    end else begin
      // slots free up after the scheduler's pulse
      if (sched_ack_i.fork_taken) begin
        req_q.fork_slot.vld <= 1'b0;
      end
      if (sched_ack_i.stop_done) begin
        req_q.stop_slot.vld <= 1'b0;
      end
      if (sched_ack_i.pause_done) begin
        req_q.pause_slot.vld <= 1'b0;
      end
      // occupied slots are never acked and filled at once
      if (accept) begin
        case (wb_req_i.adr)
          CMD_RUN:   req_q.fork_slot  <= '{vld: 1'b1, desc: thread_desc_t'(wb_req_i.dat)};
          CMD_STOP:  req_q.stop_slot  <= '{vld: 1'b1, desc: thread_desc_t'(wb_req_i.dat)};
          CMD_PAUSE: req_q.pause_slot <= '{vld: 1'b1, desc: thread_desc_t'(wb_req_i.dat)};
          default: ;
        endcase
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = {31'd0, acc_q};

  assign sched_req_o = req_q;

endmodule

// ==== rtl/wb_pkg.sv ====
package wb_pkg;

  // classic cycle from the cpu side
  // adr selects the thread command, dat holds the descriptor
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    thread_pkg::thread_cmd_e adr;
    logic [31:0]             dat;
  } wb_req_t;

  // bit 0 of dat tells whether the command was accepted
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage

// ==== rtl/thread_pkg.sv ====
package thread_pkg;

  // sized for the deepest table we support (15 entries)
  localparam int IDX_W   = 4;
  localparam int SLEEP_W = 4;

  // frame word in the upper half, code address in the lower half
  typedef struct packed {
    logic [15:0] frame;
    logic [15:0] entry;
  } thread_desc_t;

  // command code, carried on the wishbone address
  typedef enum logic [1:0] {
    CMD_RUN   = 2'd0,
    CMD_STOP  = 2'd1,
    CMD_PAUSE = 2'd2,
    CMD_RSVD  = 2'd3
  } thread_cmd_e;

  // one pending request slot
  typedef struct packed {
    logic         vld;
    thread_desc_t desc;
  } req_slot_t;

  typedef struct packed {
    req_slot_t fork_slot;
    req_slot_t stop_slot;
    req_slot_t pause_slot;
  } sched_req_t;

  typedef struct packed {
    logic fork_taken;
    logic stop_done;
    logic pause_done;
  } sched_ack_t;

  typedef enum logic [2:0] {
    TBL_NONE,
    TBL_APPEND,
    TBL_READ,
    TBL_SET_SLEEP,
    TBL_REMOVE
  } tbl_op_e;

  typedef struct packed {
    tbl_op_e            op;
    logic [IDX_W-1:0]   idx;
    thread_desc_t       desc;
    logic [SLEEP_W-1:0] sleep;
  } tbl_cmd_t;

  // registered read data plus the live entry count
  typedef struct packed {
    thread_desc_t       desc;
    logic [SLEEP_W-1:0] sleep;
    logic [IDX_W-1:0]   count;
  } tbl_rsp_t;

endpackage
